/* cpu_core.f */
+incdir+hw
hw/cpu_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/alu.sv
hw/regfile.sv
hw/stage_fsm.sv
hw/pc_unit.sv
hw/cpu_core.sv
dv/tb_cpu_core.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu_core testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f cpu_core.f \
    --top-module tb_cpu_core -o tb_cpu_core &&
./obj_dir/tb_cpu_core | tee /dev/stderr | grep -q -F ">>> PASS" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

/* dv/tb_cpu_core.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module tb_cpu_core;

    logic                    clk;
    logic                    reset_n;
    logic                    mem_valid;
    logic                    mem_ready = 1'b0;
    logic [`CPU_XLEN-1:0]    mem_addr;
    logic [`CPU_XLEN-1:0]    mem_wdata;
    logic [`CPU_WSTRB_W-1:0] mem_wstrb;
    logic [`CPU_XLEN-1:0]    mem_rdata = '0;

    logic [31:0] mem [256];             // 1 KB word addressed
    logic [31:0] prog [$];              // program under construction
    logic [31:0] fetch_exp [$];         // expected fetch addresses
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] st_addr [$];           // stores seen on the bus
    logic [31:0] st_data [$];
    logic [31:0] reads_seen [$];        // fetch and load addresses
    logic [31:0] next_slot = 32'h300;   // result area
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        busy = 1'b0;
    logic        rst_seen;
    bit          slow_mem = 1'b0;       // ready always 3 cycles late
    int          wait_left = 0;
    integer      seed = 32'h89c0da21;

    cpu_core i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %0t: %s, got %08h, expected %08h",
                               $time, what, got, exp));
        end
    endtask

    // background data mixing every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    // ------------------------------------------------------------
    // instruction encoders
    // ------------------------------------------------------------
    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};    // sw
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ------------------------------------------------------------
    // program building
    // ------------------------------------------------------------
    function automatic logic [31:0] here();
        return 32'(prog.size()) << 2;
    endfunction

    task automatic place(input logic [31:0] word);  // no fetch expectation
        prog.push_back(word);
    endtask

    task automatic emit(input logic [31:0] word);   // fetched in sequence
        fetch_exp.push_back(here());
        place(word);
    endtask

    task automatic put_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] rounded;
        rounded = value + 32'h800;      // addi sign-extends the low part
        emit(utype(rounded[31:12], rd, 7'b0110111));
        emit(itype(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic store_check(input logic [4:0] rs, input logic [31:0] value);
        emit(stype(12'(next_slot), rs, 5'd0));
        exp_addr.push_back(next_slot);
        exp_data.push_back(value);
        next_slot += 4;
    endtask

    // load, reset, wait for every expected store and compare
    task automatic run_program(input bit check_fetch);
        int cycles;
        reset_n = 1'b0;
        @(negedge clk);
        foreach (mem[i]) mem[i] = fill_word(32'(i) << 2);
        foreach (prog[i]) mem[i] = prog[i];
        mem[prog.size()] = jtype(21'd0, 5'd0);         // park in a self loop
        st_addr.delete();
        st_data.delete();
        reads_seen.delete();
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b1;
        cycles = 0;
        while (st_data.size() < exp_data.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > 5000) begin
                stop_run($sformatf("timeout: only %0d of %0d stores seen",
                                   st_data.size(), exp_data.size()));
            end
        end
        #1;
        foreach (exp_data[i]) begin
            check_eq(st_addr[i], exp_addr[i], $sformatf("store %0d address", i));
            check_eq(st_data[i], exp_data[i], $sformatf("store %0d data", i));
        end
        if (check_fetch) begin
            if (reads_seen.size() < fetch_exp.size()) stop_run("fewer fetches than expected");
            foreach (fetch_exp[i]) begin
                check_eq(reads_seen[i], fetch_exp[i], $sformatf("fetch %0d address", i));
            end
        end
        prog.delete();
        fetch_exp.delete();
        exp_addr.delete();
        exp_data.delete();
        next_slot = 32'h300;
    endtask

    // ------------------------------------------------------------
    // valid/ready memory model
    // ------------------------------------------------------------
    always begin
        @(posedge clk);
        rst_seen = !reset_n;    // driven a cycle ago so stable here
        #1;
        if (rst_seen) begin
            mem_ready = 1'b0;
            busy      = 1'b0;
        end else if (mem_ready) begin
            // transfer ended on this edge
            if (req_wstrb != '0) begin
                check_eq(32'(req_wstrb), 32'hf, "mem_wstrb of a store");
                mem[req_addr[9:2]] = req_wdata;
                st_addr.push_back(req_addr);
                st_data.push_back(req_wdata);
            end
            mem_ready = 1'b0;
            busy      = 1'b0;
            check_eq(32'(mem_valid), 32'h0, "mem_valid in the cycle after ready");
        end else if (busy || mem_valid) begin
            if (!busy) begin
                busy      = 1'b1;
                req_addr  = mem_addr;
                req_wdata = mem_wdata;
                req_wstrb = mem_wstrb;
                wait_left = slow_mem ? 3 : $unsigned($random(seed)) % 4;
                if (mem_wstrb == '0) reads_seen.push_back(mem_addr);
            end else begin      // bus must hold still
                check_eq(32'(mem_valid), 32'h1, "mem_valid while waiting");
                check_eq(mem_addr, req_addr, "mem_addr while waiting");
                check_eq(mem_wdata, req_wdata, "mem_wdata while waiting");
                check_eq(32'(mem_wstrb), 32'(req_wstrb), "mem_wstrb while waiting");
            end
            if (wait_left == 0) begin
                mem_rdata = mem[req_addr[9:2]];
                mem_ready = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reg_op_case(input logic [6:0] f7, input logic [2:0] f3,
                               input logic [31:0] exp);
        emit(rtype(f7, 5'd2, 5'd1, f3, 5'd3));     // x3 = x1 op x2
        store_check(5'd3, exp);
    endtask

    task automatic imm_op_case(input logic [11:0] imm, input logic [2:0] f3,
                               input logic [31:0] exp);
        emit(itype(imm, 5'd1, f3, 5'd4, 7'b0010011));  // x4 = x1 op imm
        store_check(5'd4, exp);
    endtask

    task automatic alu_test(input bit slow);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a  = 32'h8765_4321;     // negative as signed
        b  = 32'h0000_0013;
        sh = b[4:0];
        slow_mem = slow;
        put_const(5'd1, a);
        put_const(5'd2, b);
        reg_op_case(7'h00, 3'b000, a + b);
        reg_op_case(7'h20, 3'b000, a - b);
        reg_op_case(7'h00, 3'b001, a << sh);
        reg_op_case(7'h00, 3'b010, {31'b0, $signed(a) < $signed(b)});
        reg_op_case(7'h00, 3'b011, {31'b0, a < b});
        reg_op_case(7'h00, 3'b100, a ^ b);
        reg_op_case(7'h00, 3'b101, a >> sh);
        reg_op_case(7'h20, 3'b101, $signed(a) >>> sh);
        reg_op_case(7'h00, 3'b110, a | b);
        reg_op_case(7'h00, 3'b111, a & b);
        imm_op_case(12'hffb, 3'b000, a + 32'hffff_fffb);   // -5
        imm_op_case(12'hffb, 3'b010, {31'b0, $signed(a) < $signed(32'hffff_fffb)});
        imm_op_case(12'hffb, 3'b011, {31'b0, a < 32'hffff_fffb});
        imm_op_case(12'h5a5, 3'b100, a ^ 32'h0000_05a5);
        imm_op_case(12'h0f0, 3'b110, a | 32'h0000_00f0);
        imm_op_case(12'h8f0, 3'b111, a & 32'hffff_f8f0);
        imm_op_case({7'h00, 5'd7}, 3'b001, a << 7);
        imm_op_case({7'h00, 5'd7}, 3'b101, a >> 7);
        imm_op_case({7'h20, 5'd7}, 3'b101, $signed(a) >>> 7);
        run_program(1'b0);
        slow_mem = 1'b0;
    endtask

    task automatic upper_test();
        logic [31:0] at;
        emit(utype(20'habcde, 5'd5, 7'b0110111));      // lui
        store_check(5'd5, 32'habcd_e000);
        at = here();
        emit(utype(20'h12345, 5'd6, 7'b0010111));      // auipc
        store_check(5'd6, 32'h1234_5000 + at);
        at = here();
        emit(utype(20'hfffff, 5'd7, 7'b0010111));      // wraps below pc
        store_check(5'd7, 32'hffff_f000 + at);
        run_program(1'b0);
    endtask

    task automatic load_test();
        emit(itype(12'h280, 5'd0, 3'b010, 5'd8, 7'b0000011));
        store_check(5'd8, fill_word(32'h280));
        put_const(5'd9, 32'h290);
        emit(itype(12'hff8, 5'd9, 3'b010, 5'd10, 7'b0000011));    // -8 from base
        store_check(5'd10, fill_word(32'h288));
        run_program(1'b0);
    endtask

    // branch over a marker write, then store the marker in x20
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit taken, input int id);
        logic [31:0] pc0;
        logic [31:0] m_not;
        logic [31:0] m_taken;
        pc0     = here();
        m_not   = 32'h100 + 32'(2 * id);
        m_taken = m_not + 1;
        place(btype(13'd12, rs2, rs1, f3));
        place(itype(m_not[11:0], 5'd0, 3'b000, 5'd20, 7'b0010011));
        place(jtype(21'd8, 5'd0));
        place(itype(m_taken[11:0], 5'd0, 3'b000, 5'd20, 7'b0010011));
        fetch_exp.push_back(pc0);
        if (taken) begin
            fetch_exp.push_back(pc0 + 12);
        end else begin
            fetch_exp.push_back(pc0 + 4);
            fetch_exp.push_back(pc0 + 8);
        end
        store_check(5'd20, taken ? m_taken : m_not);
    endtask

    task automatic control_test();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] pj;
        v1 = 32'd5;
        v2 = 32'hffff_fffd;     // -3
        v3 = 32'd5;
        put_const(5'd1, v1);
        put_const(5'd2, v2);
        put_const(5'd3, v3);
        branch_case(3'b000, 5'd1, 5'd3, v1 == v3, 0);                   // beq
        branch_case(3'b000, 5'd1, 5'd2, v1 == v2, 1);
        branch_case(3'b001, 5'd1, 5'd2, v1 != v2, 2);                   // bne
        branch_case(3'b001, 5'd1, 5'd3, v1 != v3, 3);
        branch_case(3'b100, 5'd2, 5'd1, $signed(v2) < $signed(v1), 4);  // blt
        branch_case(3'b100, 5'd1, 5'd2, $signed(v1) < $signed(v2), 5);
        branch_case(3'b101, 5'd1, 5'd2, $signed(v1) >= $signed(v2), 6); // bge
        branch_case(3'b101, 5'd2, 5'd1, $signed(v2) >= $signed(v1), 7);
        branch_case(3'b110, 5'd1, 5'd2, v1 < v2, 8);                    // bltu
        branch_case(3'b110, 5'd2, 5'd1, v2 < v1, 9);
        branch_case(3'b111, 5'd2, 5'd1, v2 >= v1, 10);                  // bgeu
        branch_case(3'b111, 5'd1, 5'd2, v1 >= v2, 11);
        // jal over one word with its link in x21
        pj = here();
        place(jtype(21'd8, 5'd21));
        place(itype(12'h0ba, 5'd0, 3'b000, 5'd20, 7'b0010011));
        fetch_exp.push_back(pj);
        store_check(5'd21, pj + 4);
        // jalr to an odd sum with bit 0 dropped
        pj = here() + 8;
        put_const(5'd22, pj + 7);
        place(itype(12'd2, 5'd22, 3'b000, 5'd23, 7'b1100111));
        place(itype(12'h0bb, 5'd0, 3'b000, 5'd20, 7'b0010011));
        fetch_exp.push_back(pj);
        store_check(5'd23, pj + 4);
        run_program(1'b1);
    endtask

    task automatic x0_test();
        put_const(5'd1, 32'h1234_5678);
        emit(itype(12'h7ff, 5'd0, 3'b000, 5'd0, 7'b0010011));     // addi x0
        emit(utype(20'h12345, 5'd0, 7'b0110111));                 // lui x0
        emit(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));             // add x0
        store_check(5'd0, 32'h0);
        store_check(5'd1, 32'h1234_5678);
        run_program(1'b0);
    endtask

    initial begin
        reset_n = 1'b0;
        alu_test(1'b0);
        upper_test();
        load_test();
        control_test();
        x0_test();
        alu_test(1'b1);         // max ready delay
        $display(">>> PASS");
        $finish;
    end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    reset_n,
    // native valid/ready memory bus
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output logic [`CPU_XLEN-1:0]    mem_addr,
    output logic [`CPU_XLEN-1:0]    mem_wdata,
    output logic [`CPU_WSTRB_W-1:0] mem_wstrb,
    input  logic [`CPU_XLEN-1:0]    mem_rdata
);

    logic [`CPU_XLEN-1:0]       rs1_data;
    logic [`CPU_XLEN-1:0]       rs2_data;
    logic [`CPU_XLEN-1:0]       alu_result;
    logic                       branch_taken;
    logic [`CPU_XLEN-1:0]       pc;
    logic                       pc_advance;
    logic                       wb_en;
    logic [`CPU_REG_ADDR_W-1:0] wb_addr;
    logic [`CPU_XLEN-1:0]       wb_data;

    decode_if dec_bus ();   // decoded fields, shared by all blocks

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    stage_fsm u_stage_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .dec        (dec_bus),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_rdata  (mem_rdata),
        .pc_advance (pc_advance),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    pc_unit u_pc_unit (
        .clk          (clk),
        .reset_n      (reset_n),
        .dec          (dec_bus),
        .pc_advance   (pc_advance),
        .branch_taken (branch_taken),
        .alu_result   (alu_result),
        .pc           (pc)
    );

    instr_decoder u_instr_decoder (
        .dec (dec_bus)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    regfile u_regfile (
        .clk      (clk),
        .reset_n  (reset_n),
        .rf       (dec_bus),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .dec          (dec_bus),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module pc_unit (
    input  logic                 clk,
    input  logic                 reset_n,
    decode_if.pc                 dec,
    input  logic                 pc_advance,
    input  logic                 branch_taken,
    input  logic [`CPU_XLEN-1:0] alu_result,
    output logic [`CPU_XLEN-1:0] pc
);

    logic [`CPU_XLEN-1:0] pc_rel;       // branch and jal target
    logic [`CPU_XLEN-1:0] pc_next;

    assign pc_rel = pc + dec.imm;

    // ------------------------------------------------------------
    // next pc select
    // ------------------------------------------------------------
    always_comb begin
        if (dec.branch && branch_taken) begin
            pc_next = pc_rel;
        end else if (dec.jump_reg) begin
            pc_next = {alu_result[`CPU_XLEN-1:1], 1'b0};    // jalr clears bit 0
        end else if (dec.jump) begin
            pc_next = pc_rel;
        end else begin
            pc_next = pc + `CPU_PC_STEP;    // sequential, also unknown opcodes
        end
    end

    // moves once per instruction, end of WRITEBACK
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= `CPU_RESET_PC;
        end else if (pc_advance) begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/stage_fsm.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module stage_fsm (
    input  logic                       clk,
    input  logic                       reset_n,
    decode_if.fsm                      dec,
    input  logic [`CPU_XLEN-1:0]       pc,
    input  logic [`CPU_XLEN-1:0]       alu_result,
    input  logic [`CPU_XLEN-1:0]       rs2_data,
    output logic                       mem_valid,
    input  logic                       mem_ready,
    output logic [`CPU_XLEN-1:0]       mem_addr,
    output logic [`CPU_XLEN-1:0]       mem_wdata,
    output logic [`CPU_WSTRB_W-1:0]    mem_wstrb,
    input  logic [`CPU_XLEN-1:0]       mem_rdata,
    output logic                       pc_advance,
    output logic                       wb_en,
    output logic [`CPU_REG_ADDR_W-1:0] wb_addr,
    output logic [`CPU_XLEN-1:0]       wb_data
);

    cpu_pkg::stage_t      stage_q;
    cpu_pkg::stage_t      stage_next;
    logic [`CPU_XLEN-1:0] instr_q;
    logic [`CPU_XLEN-1:0] load_q;       // lw data
    logic                 in_fetch;
    logic                 in_mem;
    logic                 storing;

    assign in_fetch  = stage_q == cpu_pkg::FETCH;
    assign in_mem    = stage_q == cpu_pkg::MEMORY;
    assign storing   = in_mem && dec.mem_write;
    assign dec.instr = instr_q;

    // ------------------------------------------------------------
    // stage sequencing
    // ------------------------------------------------------------
    always_comb begin
        stage_next = stage_q;
        case (stage_q)
            cpu_pkg::FETCH:     if (mem_ready) stage_next = cpu_pkg::EXECUTE;
            cpu_pkg::EXECUTE:   stage_next = (dec.mem_read || dec.mem_write) ?
                                             cpu_pkg::MEMORY : cpu_pkg::WRITEBACK;
            cpu_pkg::MEMORY:    if (mem_ready) stage_next = cpu_pkg::WRITEBACK;
            default:            stage_next = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage_q <= cpu_pkg::FETCH;
            instr_q <= '0;              // decodes as a no-op
        end else begin
            stage_q <= stage_next;
            if (in_fetch && mem_ready) instr_q <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (in_mem && mem_ready) load_q <= mem_rdata;   // only on the ready edge
    end

    // bus, held stable while waiting on mem_ready
    assign mem_valid = in_fetch || in_mem;
    assign mem_addr  = in_fetch ? pc : (in_mem ? alu_result : '0);
    assign mem_wdata = storing ? rs2_data : '0;
    assign mem_wstrb = storing ? '1 : '0;

    // writeback
    assign pc_advance = stage_q == cpu_pkg::WRITEBACK;
    assign wb_en      = pc_advance && dec.reg_write;
    assign wb_addr    = dec.rd;
    assign wb_data    = dec.mem_read ? load_q :
                        dec.jump     ? pc + `CPU_PC_STEP    // link address
                                     : alu_result;

endmodule

/* hw/regfile.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module regfile (
    input  logic                       clk,
    input  logic                       reset_n,
    decode_if.rf                       rf,
    input  logic                       wb_en,
    input  logic [`CPU_REG_ADDR_W-1:0] wb_addr,
    input  logic [`CPU_XLEN-1:0]       wb_data,
    output logic [`CPU_XLEN-1:0]       rs1_data,
    output logic [`CPU_XLEN-1:0]       rs2_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    // single write port, end of WRITEBACK
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;   // x0 may be written, never read back
        end
    end

    // combinational reads
    assign rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
    assign rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module alu (
    decode_if.exe               dec,
    input  logic [`CPU_XLEN-1:0] rs1_data,
    input  logic [`CPU_XLEN-1:0] rs2_data,
    input  logic [`CPU_XLEN-1:0] pc,
    output logic [`CPU_XLEN-1:0] alu_result,
    output logic                 branch_taken
);

    logic [`CPU_XLEN-1:0] in1;
    logic [`CPU_XLEN-1:0] in2;
    logic [4:0]           shamt;

    // ------------------------------------------------------------
    // operand select
    // ------------------------------------------------------------
    always_comb begin
        case (dec.in1_src)
            cpu_pkg::IN1_ZERO: in1 = '0;
            cpu_pkg::IN1_PC:   in1 = pc;
            default:           in1 = rs1_data;
        endcase
    end

    assign in2   = dec.in2_is_reg ? rs2_data : dec.imm;
    assign shamt = in2[4:0];        // rv32 shifts use the low five bits

    always_comb begin
        case (dec.alu_op)
            cpu_pkg::ADD:  alu_result = in1 + in2;
            cpu_pkg::SUB:  alu_result = in1 - in2;
            cpu_pkg::SLL:  alu_result = in1 << shamt;
            cpu_pkg::SLT:  alu_result = {31'b0, $signed(in1) < $signed(in2)};
            cpu_pkg::SLTU: alu_result = {31'b0, in1 < in2};
            cpu_pkg::XOR:  alu_result = in1 ^ in2;
            cpu_pkg::SRL:  alu_result = in1 >> shamt;
            cpu_pkg::SRA:  alu_result = $signed(in1) >>> shamt;
            cpu_pkg::OR:   alu_result = in1 | in2;
            default:       alu_result = in1 & in2;     // AND
        endcase
    end

    // branch compare on the raw register values
    always_comb begin
        case (dec.branch_funct)
            3'b000:  branch_taken = rs1_data == rs2_data;                   // beq
            3'b001:  branch_taken = rs1_data != rs2_data;                   // bne
            3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);  // blt
            3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data); // bge
            3'b110:  branch_taken = rs1_data < rs2_data;                    // bltu
            3'b111:  branch_taken = rs1_data >= rs2_data;                   // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module instr_decoder (
    decode_if.dec dec
);

    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CPU_XLEN-1:0] i_imm;
    logic [`CPU_XLEN-1:0] s_imm;
    logic [`CPU_XLEN-1:0] b_imm;
    logic [`CPU_XLEN-1:0] u_imm;
    logic [`CPU_XLEN-1:0] j_imm;
    logic [`CPU_XLEN-1:0] shamt_imm;

    // funct3 to alu op, shared by OP and OP_IMM
    function automatic cpu_pkg::alu_op_t funct_to_alu(input logic [2:0] f3,
                                                     input logic       sub_sel,
                                                     input logic       sra_sel);
        cpu_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sub_sel ? cpu_pkg::SUB : cpu_pkg::ADD;
            3'b001:  op = cpu_pkg::SLL;
            3'b010:  op = cpu_pkg::SLT;
            3'b011:  op = cpu_pkg::SLTU;
            3'b100:  op = cpu_pkg::XOR;
            3'b101:  op = sra_sel ? cpu_pkg::SRA : cpu_pkg::SRL;
            3'b110:  op = cpu_pkg::OR;
            default: op = cpu_pkg::AND;
        endcase
        return op;
    endfunction

    // ------------------------------------------------------------
    // fixed instruction fields
    // ------------------------------------------------------------
    assign funct3           = dec.instr[14:12];
    assign funct7           = dec.instr[31:25];
    assign dec.rs1          = dec.instr[19:15];
    assign dec.rs2          = dec.instr[24:20];
    assign dec.rd           = dec.instr[11:7];
    assign dec.branch_funct = funct3;

    // immediate formats
    assign i_imm = {{20{dec.instr[31]}}, dec.instr[31:20]};
    assign s_imm = {{20{dec.instr[31]}}, dec.instr[31:25], dec.instr[11:7]};
    assign b_imm = {{19{dec.instr[31]}}, dec.instr[31], dec.instr[7],
                    dec.instr[30:25], dec.instr[11:8], 1'b0};
    assign u_imm = {dec.instr[31:12], 12'b0};
    assign j_imm = {{11{dec.instr[31]}}, dec.instr[31], dec.instr[19:12],
                    dec.instr[20], dec.instr[30:21], 1'b0};
    assign shamt_imm = {27'b0, dec.instr[24:20]};   // funct7 bits not part of it

    // ------------------------------------------------------------
    // control per opcode
    // ------------------------------------------------------------
    always_comb begin
        // unknown opcode falls through as a no-op
        dec.alu_op     = cpu_pkg::ADD;
        dec.in1_src    = cpu_pkg::IN1_RS1;
        dec.in2_is_reg = 1'b0;
        dec.imm        = i_imm;
        dec.reg_write  = 1'b0;
        dec.mem_read   = 1'b0;
        dec.mem_write  = 1'b0;
        dec.branch     = 1'b0;
        dec.jump       = 1'b0;
        dec.jump_reg   = 1'b0;
        case (cpu_pkg::opcode_t'(dec.instr[6:0]))
            cpu_pkg::LOAD: begin            // lw, address rs1 + imm
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            cpu_pkg::STORE: begin           // sw
                dec.mem_write = 1'b1;
                dec.imm       = s_imm;
            end
            cpu_pkg::OP_IMM: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = funct_to_alu(funct3, 1'b0, funct7 == 7'h20);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    dec.imm = shamt_imm;    // slli, srli, srai
                end
            end
            cpu_pkg::OP: begin              // funct7 picks sub and sra
                dec.reg_write  = 1'b1;
                dec.in2_is_reg = 1'b1;
                dec.alu_op     = funct_to_alu(funct3, funct7 == 7'h20, funct7 == 7'h20);
            end
            cpu_pkg::LUI: begin             // 0 + imm
                dec.reg_write = 1'b1;
                dec.in1_src   = cpu_pkg::IN1_ZERO;
                dec.imm       = u_imm;
            end
            cpu_pkg::AUIPC: begin           // pc + imm
                dec.reg_write = 1'b1;
                dec.in1_src   = cpu_pkg::IN1_PC;
                dec.imm       = u_imm;
            end
            cpu_pkg::JAL: begin
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
                dec.imm       = j_imm;
            end
            cpu_pkg::JALR: begin            // target from alu, rs1 + imm
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
                dec.jump_reg  = 1'b1;
            end
            cpu_pkg::BRANCH: begin
                dec.branch     = 1'b1;
                dec.in2_is_reg = 1'b1;
                dec.alu_op     = cpu_pkg::SUB;
                dec.imm        = b_imm;
            end
            default: ;
        endcase
    end

endmodule

/* hw/decode_if.sv */
`timescale 1ns/10ps
`include "cpu_defines.svh"

interface decode_if;
    logic [`CPU_XLEN-1:0]       instr;          // latched instruction word
    logic [`CPU_REG_ADDR_W-1:0] rs1;
    logic [`CPU_REG_ADDR_W-1:0] rs2;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_XLEN-1:0]       imm;            // sign-extended per format
    cpu_pkg::alu_op_t           alu_op;
    cpu_pkg::alu_in1_t          in1_src;
    logic                       in2_is_reg;     // rs2 instead of imm
    logic                       reg_write;
    logic                       mem_read;       // lw
    logic                       mem_write;      // sw
    logic                       branch;
    logic                       jump;           // jal or jalr
    logic                       jump_reg;       // jalr only
    logic [2:0]                 branch_funct;   // funct3 of a branch

    modport dec (input instr, output rs1, rs2, rd, imm, alu_op, in1_src, in2_is_reg,
                 reg_write, mem_read, mem_write, branch, jump, jump_reg, branch_funct);
    modport fsm (output instr, input reg_write, mem_read, mem_write, jump, rd);
    modport exe (input alu_op, in1_src, in2_is_reg, imm, branch_funct);
    modport pc  (input branch, jump, jump_reg, imm);
    modport rf  (input rs1, rs2);
endinterface

/* hw/cpu_pkg.sv */
package cpu_pkg;

    // ------------------------------------------------------------
    // stage sequence of the multi-cycle core
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        FETCH,      // instruction read on the bus
        EXECUTE,    // decode and alu
        MEMORY,     // lw or sw on the bus
        WRITEBACK   // register write and pc update
    } stage_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_t;

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_t;

    // first operand source
    typedef enum logic [1:0] {
        IN1_ZERO,   // lui
        IN1_RS1,    // most forms
        IN1_PC      // auipc
    } alu_in1_t;

endpackage

/* hw/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ------------------------------------------------------------
// datapath and register file sizing
// ------------------------------------------------------------
`define CPU_XLEN        32              // data and address width
`define CPU_REG_ADDR_W  5               // register index width
`define CPU_REG_COUNT   32              // x0 .. x31

// ------------------------------------------------------------
// program counter
// ------------------------------------------------------------
`define CPU_RESET_PC    32'h0000_0000   // first fetch address
`define CPU_PC_STEP     32'd4           // one 32-bit instruction

// ------------------------------------------------------------
// memory bus
// ------------------------------------------------------------
// one strobe bit per byte lane, all ones on a store
`define CPU_WSTRB_W     4

`endif
